//--- Makefile
# Verilator simulation of the external device subsystem

VERILATOR ?= verilator
TOP       ?= tb_ext_dev
LOG       ?= sim.log
SEED      ?= 1
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing -Wno-fatal --x-assign unique --x-initial unique

SOURCES := $(wildcard rtl/*.sv tb/*.sv tb/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: SEED=$(SEED) TOP=$(TOP) LOG=$(LOG) BUILD_DIR=$(BUILD_DIR)"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) +verilator+rand+reset+2 > $(LOG) 2>&1
	@if grep -q "Simulation FAILED" $(LOG); then \
	  echo "Test failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
	  echo "No result found in $(LOG)"; exit 1; \
	else \
	  echo "Test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/ext_dev_pkg.sv
// Shared data and register-bus widths, register map and status bits
// Memory word view used for byte-enable merging

package ext_dev_pkg;

  // Data path
  localparam int unsigned DATA_W = 32;

  // Register bus address width
  localparam int unsigned REG_ADDR_W = 4;

  // Register byte offsets
  localparam logic [REG_ADDR_W-1:0] REG_SRC  = 4'h0;
  localparam logic [REG_ADDR_W-1:0] REG_DST  = 4'h4;
  localparam logic [REG_ADDR_W-1:0] REG_SIZE = 4'h8;
  localparam logic [REG_ADDR_W-1:0] REG_CTRL = 4'hC;

  // Control write bit
  localparam int unsigned CTRL_START_BIT = 0;

  // Status read bits
  localparam int unsigned STAT_BUSY_BIT = 0;
  localparam int unsigned STAT_DONE_BIT = 1;

  // One memory word, seen as a whole or byte by byte
  typedef union packed {
    logic [DATA_W-1:0]        word;
    logic [DATA_W/8-1:0][7:0] bytes;
  } mem_word_u;

endpackage

//--- rtl/ext_dev_top.sv
// External device top: copy peripheral, its counter and the slow memory
// Memory port 0 is external, port 1 belongs to the copy engine

`timescale 1ns/1ps

module ext_dev_top
  import ext_dev_pkg::*;
#(
  parameter int unsigned NUM_WORDS = 128
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Register bus
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [DATA_W-1:0]     reg_wdata_i,
  output logic                  reg_ready_o,
  output logic [DATA_W-1:0]     reg_rdata_o,
  output logic                  reg_error_o,
  // External memory port
  input  logic                  ext_p0_req_i,
  input  logic                  ext_p0_we_i,
  input  logic [DATA_W-1:0]     ext_p0_addr_i,
  input  logic [DATA_W-1:0]     ext_p0_wdata_i,
  input  logic [DATA_W/8-1:0]   ext_p0_be_i,
  output logic                  ext_p0_gnt_o,
  output logic [DATA_W-1:0]     ext_p0_rdata_o,
  output logic                  ext_p0_rvalid_o,
  output logic                  memcopy_intr_o
);

  logic                start;
  logic                busy;
  logic                done;
  logic [DATA_W-1:0]   src_addr;
  logic [DATA_W-1:0]   dst_addr;
  logic [DATA_W-1:0]   size;
  logic                load;
  logic                step;
  logic [DATA_W-1:0]   offset;
  logic                last;
  // Engine master port
  logic                obi_req;
  logic                obi_we;
  logic [DATA_W-1:0]   obi_addr;
  logic [DATA_W-1:0]   obi_wdata;
  logic [DATA_W/8-1:0] obi_be;
  logic                obi_gnt;
  logic [DATA_W-1:0]   obi_rdata;
  logic                obi_rvalid;

  memcopy_regs #(
    .NUM_WORDS(NUM_WORDS)
  ) memcopy_regs_i (
    .clk_i,
    .rst_n_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_ready_o,
    .reg_rdata_o,
    .reg_error_o,
    .busy_i    (busy),
    .done_i    (done),
    .start_o   (start),
    .src_addr_o(src_addr),
    .dst_addr_o(dst_addr),
    .size_o    (size)
  );

  memcopy_ctrl memcopy_ctrl_i (
    .clk_i,
    .rst_n_i,
    .start_i     (start),
    .src_addr_i  (src_addr),
    .dst_addr_i  (dst_addr),
    .offset_i    (offset),
    .last_i      (last),
    .load_o      (load),
    .step_o      (step),
    .busy_o      (busy),
    .done_o      (done),
    .intr_o      (memcopy_intr_o),
    .obi_req_o   (obi_req),
    .obi_we_o    (obi_we),
    .obi_addr_o  (obi_addr),
    .obi_wdata_o (obi_wdata),
    .obi_be_o    (obi_be),
    .obi_gnt_i   (obi_gnt),
    .obi_rdata_i (obi_rdata),
    .obi_rvalid_i(obi_rvalid)
  );

  xfer_counter xfer_counter_i (
    .clk_i,
    .rst_n_i,
    .load_i  (load),
    .size_i  (size),
    .step_i  (step),
    .offset_o(offset),
    .last_o  (last)
  );

  slow_memory #(
    .NUM_WORDS(NUM_WORDS)
  ) slow_memory_i (
    .clk_i,
    .rst_n_i,
    .p0_req_i   (ext_p0_req_i),
    .p0_we_i    (ext_p0_we_i),
    .p0_addr_i  (ext_p0_addr_i),
    .p0_wdata_i (ext_p0_wdata_i),
    .p0_be_i    (ext_p0_be_i),
    .p0_gnt_o   (ext_p0_gnt_o),
    .p0_rdata_o (ext_p0_rdata_o),
    .p0_rvalid_o(ext_p0_rvalid_o),
    .p1_req_i   (obi_req),
    .p1_we_i    (obi_we),
    .p1_addr_i  (obi_addr),
    .p1_wdata_i (obi_wdata),
    .p1_be_i    (obi_be),
    .p1_gnt_o   (obi_gnt),
    .p1_rdata_o (obi_rdata),
    .p1_rvalid_o(obi_rvalid)
  );

endmodule

//--- rtl/memcopy_ctrl.sv
// Copy engine FSM driving the OBI master port
// One read and one write per word, each waiting for gnt then rvalid

`timescale 1ns/1ps

module memcopy_ctrl
  import ext_dev_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic [DATA_W-1:0]   src_addr_i,
  input  logic [DATA_W-1:0]   dst_addr_i,
  input  logic [DATA_W-1:0]   offset_i,
  input  logic                last_i,
  output logic                load_o,
  output logic                step_o,
  output logic                busy_o,
  output logic                done_o,
  output logic                intr_o,
  output logic                obi_req_o,
  output logic                obi_we_o,
  output logic [DATA_W-1:0]   obi_addr_o,
  output logic [DATA_W-1:0]   obi_wdata_o,
  output logic [DATA_W/8-1:0] obi_be_o,
  input  logic                obi_gnt_i,
  input  logic [DATA_W-1:0]   obi_rdata_i,
  input  logic                obi_rvalid_i
);

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_RD_REQ  = 3'd1;
  localparam logic [2:0] ST_RD_WAIT = 3'd2;
  localparam logic [2:0] ST_WR_REQ  = 3'd3;
  localparam logic [2:0] ST_WR_WAIT = 3'd4;

  logic [2:0]        state_q;
  logic [2:0]        state_d;
  logic [DATA_W-1:0] src_base_q;
  logic [DATA_W-1:0] dst_base_q;
  logic [DATA_W-1:0] wdata_q;
  logic              intr_q;
  logic              word_done;

  // Write of the current word acknowledged
  assign word_done = (state_q == ST_WR_WAIT) && obi_rvalid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_RD_REQ;
        end
      end
      ST_RD_REQ: begin
        if (obi_gnt_i) begin
          state_d = ST_RD_WAIT;
        end
      end
      ST_RD_WAIT: begin
        if (obi_rvalid_i) begin
          state_d = ST_WR_REQ;
        end
      end
      ST_WR_REQ: begin
        if (obi_gnt_i) begin
          state_d = ST_WR_WAIT;
        end
      end
      ST_WR_WAIT: begin
        if (obi_rvalid_i) begin
          state_d = last_i ? ST_IDLE : ST_RD_REQ;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      intr_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Lands in the first idle cycle, together with the done flag
      intr_q  <= word_done && last_i;
    end
  end

  // Transfer bases captured at start, read word held for the write
  always_ff @(posedge clk_i) begin
    if (load_o) begin
      src_base_q <= src_addr_i;
      dst_base_q <= dst_addr_i;
    end
    if ((state_q == ST_RD_WAIT) && obi_rvalid_i) begin
      wdata_q <= obi_rdata_i;
    end
  end

  assign load_o = (state_q == ST_IDLE) && start_i;
  assign step_o = word_done;
  assign done_o = word_done && last_i;
  assign busy_o = (state_q != ST_IDLE);
  assign intr_o = intr_q;

  // OBI request fields stay stable while waiting for gnt
  assign obi_req_o   = (state_q == ST_RD_REQ) || (state_q == ST_WR_REQ);
  assign obi_we_o    = (state_q == ST_WR_REQ);
  assign obi_addr_o  = ((state_q == ST_WR_REQ) ? dst_base_q : src_base_q) + offset_i;
  assign obi_wdata_o = wdata_q;
  assign obi_be_o    = '1;

endmodule

//--- rtl/memcopy_regs.sv
// Register bank of the memory-copy peripheral
// Source, destination, size and control/status on the register bus

`timescale 1ns/1ps

module memcopy_regs
  import ext_dev_pkg::*;
#(
  parameter int unsigned NUM_WORDS = 128
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [DATA_W-1:0]     reg_wdata_i,
  output logic                  reg_ready_o,
  output logic [DATA_W-1:0]     reg_rdata_o,
  output logic                  reg_error_o,
  input  logic                  busy_i,
  input  logic                  done_i,
  output logic                  start_o,
  output logic [DATA_W-1:0]     src_addr_o,
  output logic [DATA_W-1:0]     dst_addr_o,
  output logic [DATA_W-1:0]     size_o
);

  logic [DATA_W-1:0] src_q;
  logic [DATA_W-1:0] dst_q;
  logic [DATA_W-1:0] size_q;
  logic              done_q;
  logic              sel_src;
  logic              sel_dst;
  logic              sel_size;
  logic              sel_ctrl;
  logic              size_ok;
  logic              wr_en;

  // Address decode
  assign sel_src  = (reg_addr_i == REG_SRC);
  assign sel_dst  = (reg_addr_i == REG_DST);
  assign sel_size = (reg_addr_i == REG_SIZE);
  assign sel_ctrl = (reg_addr_i == REG_CTRL);

  // Size must lie in 1..NUM_WORDS
  assign size_ok = (reg_wdata_i != '0) && (reg_wdata_i <= DATA_W'(NUM_WORDS));

  // Every access completes in the cycle it is presented
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i &&
                       (!(sel_src || sel_dst || sel_size || sel_ctrl) ||
                        (reg_write_i && sel_size && !size_ok));

  assign wr_en   = reg_valid_i && reg_write_i && !reg_error_o;
  assign start_o = wr_en && sel_ctrl && reg_wdata_i[CTRL_START_BIT] && !busy_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q  <= '0;
      dst_q  <= '0;
      size_q <= '0;
      done_q <= 1'b0;
    end else begin
      if (wr_en && sel_src) begin
        src_q <= reg_wdata_i;
      end
      if (wr_en && sel_dst) begin
        dst_q <= reg_wdata_i;
      end
      if (wr_en && sel_size) begin
        size_q <= reg_wdata_i;
      end
      // Done is sticky until the next accepted start
      if (done_i) begin
        done_q <= 1'b1;
      end else if (start_o) begin
        done_q <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    reg_rdata_o = '0;
    if (sel_src) begin
      reg_rdata_o = src_q;
    end else if (sel_dst) begin
      reg_rdata_o = dst_q;
    end else if (sel_size) begin
      reg_rdata_o = size_q;
    end else if (sel_ctrl) begin
      reg_rdata_o[STAT_BUSY_BIT] = busy_i;
      reg_rdata_o[STAT_DONE_BIT] = done_q;
    end
  end

  assign src_addr_o = src_q;
  assign dst_addr_o = dst_q;
  assign size_o     = size_q;

endmodule

//--- rtl/slow_memory.sv
// Two-port word memory with OBI-style req/gnt/rvalid handshakes
// Port 0 has fixed priority, grant delay comes from a small LFSR

`timescale 1ns/1ps

module slow_memory
  import ext_dev_pkg::*;
#(
  parameter int unsigned NUM_WORDS = 128
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                p0_req_i,
  input  logic                p0_we_i,
  input  logic [DATA_W-1:0]   p0_addr_i,
  input  logic [DATA_W-1:0]   p0_wdata_i,
  input  logic [DATA_W/8-1:0] p0_be_i,
  output logic                p0_gnt_o,
  output logic [DATA_W-1:0]   p0_rdata_o,
  output logic                p0_rvalid_o,
  input  logic                p1_req_i,
  input  logic                p1_we_i,
  input  logic [DATA_W-1:0]   p1_addr_i,
  input  logic [DATA_W-1:0]   p1_wdata_i,
  input  logic [DATA_W/8-1:0] p1_be_i,
  output logic                p1_gnt_o,
  output logic [DATA_W-1:0]   p1_rdata_o,
  output logic                p1_rvalid_o
);

  localparam int unsigned AW   = $clog2(NUM_WORDS);
  localparam int unsigned BE_W = DATA_W / 8;

  logic [DATA_W-1:0] mem_q [NUM_WORDS];
  logic [2:0]        lfsr_q;
  logic              lfsr_fb;
  logic              wait_q;
  logic [2:0]        cnt_q;
  logic              sel_q;
  logic              sel;
  logic              active;
  logic              gnt;
  logic [2:0]        wait_left;
  logic              g_we;
  logic [DATA_W-1:0] g_addr;
  logic [DATA_W-1:0] g_wdata;
  logic [BE_W-1:0]   g_be;
  logic [AW-1:0]     g_idx;
  mem_word_u         in_word;
  mem_word_u         old_word;
  mem_word_u         new_word;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid0_q;
  logic              rvalid1_q;

  // Extra term on 00 lets the sequence pass through zero, giving delays 0 to 7
  assign lfsr_fb = lfsr_q[2] ^ lfsr_q[1] ^ (lfsr_q[1:0] == 2'b00);

  // Winner is picked when idle and kept until its grant
  assign sel       = wait_q ? sel_q : !p0_req_i;
  assign active    = wait_q || p0_req_i || p1_req_i;
  assign wait_left = wait_q ? cnt_q : lfsr_q;
  assign gnt       = active && (wait_left == 3'd0);

  assign g_we    = sel ? p1_we_i    : p0_we_i;
  assign g_addr  = sel ? p1_addr_i  : p0_addr_i;
  assign g_wdata = sel ? p1_wdata_i : p0_wdata_i;
  assign g_be    = sel ? p1_be_i    : p0_be_i;
  assign g_idx   = g_addr[AW+1:2];

  // Byte-enable merge
  always_comb begin
    in_word.word  = g_wdata;
    old_word.word = mem_q[g_idx];
    new_word      = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (g_be[b]) begin
        new_word.bytes[b] = in_word.bytes[b];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lfsr_q    <= 3'b001;
      wait_q    <= 1'b0;
      cnt_q     <= '0;
      sel_q     <= 1'b0;
      rvalid0_q <= 1'b0;
      rvalid1_q <= 1'b0;
    end else begin
      lfsr_q    <= {lfsr_q[1:0], lfsr_fb};
      rvalid0_q <= gnt && !sel;
      rvalid1_q <= gnt && sel;
      if (gnt) begin
        wait_q <= 1'b0;
      end else if (active) begin
        wait_q <= 1'b1;
        cnt_q  <= wait_left - 3'd1;
        sel_q  <= sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (g_we) begin
        mem_q[g_idx] <= new_word.word;
      end else begin
        rdata_q <= mem_q[g_idx];
      end
    end
  end

  assign p0_gnt_o    = gnt && !sel;
  assign p1_gnt_o    = gnt && sel;
  assign p0_rdata_o  = rdata_q;
  assign p1_rdata_o  = rdata_q;
  assign p0_rvalid_o = rvalid0_q;
  assign p1_rvalid_o = rvalid1_q;

endmodule

//--- rtl/xfer_counter.sv
// Remaining-word counter and byte offset of a copy

`timescale 1ns/1ps

module xfer_counter
  import ext_dev_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              load_i,
  input  logic [DATA_W-1:0] size_i,
  input  logic              step_i,
  output logic [DATA_W-1:0] offset_o,
  output logic              last_o
);

  logic [DATA_W-1:0] remaining_q;
  logic [DATA_W-1:0] offset_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      remaining_q <= '0;
      offset_q    <= '0;
    end else if (load_i) begin
      remaining_q <= size_i;
      offset_q    <= '0;
    end else if (step_i) begin
      remaining_q <= remaining_q - 1'b1;
      // Byte offset of the next word
      offset_q    <= offset_q + DATA_W'(4);
    end
  end

  assign offset_o = offset_q;
  assign last_o   = (remaining_q == DATA_W'(1));

endmodule

//--- sim.f
+incdir+tb
rtl/ext_dev_pkg.sv
rtl/memcopy_regs.sv
rtl/memcopy_ctrl.sv
rtl/xfer_counter.sv
rtl/slow_memory.sv
rtl/ext_dev_top.sv
tb/tb_ext_dev.sv

//--- tb/tb_ext_dev_tasks.svh
// Register-bus and port 0 driver tasks, memory reference model
// Copy setup helpers and the value check

task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                           input logic [DATA_W-1:0] actual);
  if (actual !== expected) begin
    $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "value mismatch");
  end
endtask

// Ready and error come back in the cycle valid is high
task automatic reg_access(input logic wr, input logic [REG_ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                          output logic error);
  @(posedge clk);
  reg_valid <= 1'b1;
  reg_write <= wr;
  reg_addr  <= addr;
  reg_wdata <= wdata;
  @(negedge clk);
  check_value("reg ready", 1, reg_ready);
  rdata = reg_rdata;
  error = reg_error;
  @(posedge clk);
  reg_valid <= 1'b0;
endtask

task automatic reg_write_ok(input logic [REG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
  logic [DATA_W-1:0] rdata;
  logic              error;
  reg_access(1'b1, addr, wdata, rdata, error);
  check_value("reg write error", 0, error);
endtask

task automatic reg_read_ok(input logic [REG_ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
  logic error;
  reg_access(1'b0, addr, '0, rdata, error);
  check_value("reg read error", 0, error);
endtask

// Hold req until gnt and expect rvalid one cycle later
task automatic mem_access(input logic wr, input int unsigned idx, input logic [DATA_W-1:0] wdata,
                          input logic [BE_W-1:0] be, output logic [DATA_W-1:0] rdata);
  @(posedge clk);
  p0_req   <= 1'b1;
  p0_we    <= wr;
  p0_addr  <= DATA_W'(idx * 4);
  p0_wdata <= wdata;
  p0_be    <= be;
  @(negedge clk);
  while (!p0_gnt) begin
    @(negedge clk);
  end
  @(posedge clk);
  p0_req <= 1'b0;
  @(negedge clk);
  check_value("port 0 rvalid", 1, p0_rvalid);
  rdata = p0_rdata;
endtask

// Byte-enable merge through the byte view
function automatic void model_write(input int unsigned idx, input logic [DATA_W-1:0] wdata,
                                    input logic [BE_W-1:0] be);
  mem_word_u cur;
  mem_word_u upd;
  cur.word = model_mem[idx];
  upd.word = wdata;
  for (int b = 0; b < BE_W; b++) begin
    if (be[b]) begin
      cur.bytes[b] = upd.bytes[b];
    end
  end
  model_mem[idx] = cur.word;
endfunction

task automatic preload_memory();
  logic [DATA_W-1:0] rdata;
  for (int unsigned i = 0; i < NUM_WORDS; i++) begin
    model_mem[i] = $urandom;
    mem_access(1'b1, i, model_mem[i], '1, rdata);
  end
endtask

task automatic check_memory(input string name);
  logic [DATA_W-1:0] rdata;
  for (int unsigned i = 0; i < NUM_WORDS; i++) begin
    mem_access(1'b0, i, '0, '0, rdata);
    check_value($sformatf("%s word %0d", name, i), model_mem[i], rdata);
  end
endtask

// Lower range first, then a random gap, then the upper range
task automatic pick_copy(input int unsigned min_size, input int unsigned max_size,
                         output int unsigned src, output int unsigned dst,
                         output int unsigned size);
  int unsigned lo;
  int unsigned hi;
  size = min_size + $urandom % (max_size - min_size + 1);
  lo   = $urandom % (NUM_WORDS - 2 * size + 1);
  hi   = lo + size + $urandom % (NUM_WORDS - 2 * size - lo + 1);
  if ($urandom % 2 == 0) begin
    src = lo;
    dst = hi;
  end else begin
    src = hi;
    dst = lo;
  end
endtask

task automatic start_copy(input int unsigned src, input int unsigned dst,
                          input int unsigned size);
  reg_write_ok(REG_SRC, DATA_W'(src * 4));
  reg_write_ok(REG_DST, DATA_W'(dst * 4));
  reg_write_ok(REG_SIZE, DATA_W'(size));
  reg_write_ok(REG_CTRL, DATA_W'(1) << CTRL_START_BIT);
  copies_started++;
  for (int unsigned i = 0; i < size; i++) begin
    model_mem[dst + i] = model_mem[src + i];
  end
endtask

task automatic wait_copy_done();
  while (intr_count < copies_started) begin
    @(negedge clk);
  end
endtask

//--- tb/tb_ext_dev.sv
// Testbench for the external device subsystem
// Clock, reset, DUT, timeout and the test sequence

`timescale 1ns/1ps

module tb_ext_dev
  import ext_dev_pkg::*;
();

  localparam int unsigned NUM_WORDS   = 128;
  localparam int unsigned BE_W        = DATA_W / 8;
  localparam int unsigned NUM_COPIES  = 6;
  localparam int unsigned MAX_COPY    = 32;
  localparam int unsigned NUM_BYTE_WR = 16;
  // Worst grant delay plus the rvalid cycle
  localparam int unsigned TXN_CYCLES  = 9;
  // Preload, byte test, full readback after every copy, extra port 0 accesses
  localparam int unsigned P0_TXNS     = NUM_WORDS + 2 * NUM_BYTE_WR +
                                        (NUM_COPIES + 2) * NUM_WORDS + 16;
  localparam int unsigned ENG_TXNS    = (NUM_COPIES + 2) * MAX_COPY * 2;
  // A port 0 access may also sit behind one engine access
  localparam int unsigned TIMEOUT_CYCLES = (ENG_TXNS + 2 * P0_TXNS) * TXN_CYCLES + 2000;
  localparam logic [REG_ADDR_W-1:0] CFG_REGS [3] = '{REG_SRC, REG_DST, REG_SIZE};

  logic                  clk;
  logic                  rst_n;
  logic                  reg_valid;
  logic                  reg_write;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [DATA_W-1:0]     reg_wdata;
  logic                  reg_ready;
  logic [DATA_W-1:0]     reg_rdata;
  logic                  reg_error;
  logic                  p0_req;
  logic                  p0_we;
  logic [DATA_W-1:0]     p0_addr;
  logic [DATA_W-1:0]     p0_wdata;
  logic [BE_W-1:0]       p0_be;
  logic                  p0_gnt;
  logic [DATA_W-1:0]     p0_rdata;
  logic                  p0_rvalid;
  logic                  memcopy_intr;

  // Expected memory contents and register values
  logic [DATA_W-1:0]     model_mem [NUM_WORDS];
  logic [DATA_W-1:0]     cfg_shadow [3];
  int unsigned           copies_started = 0;
  int unsigned           intr_count = 0;
  int unsigned           cycle_count = 0;

  `include "tb_ext_dev_tasks.svh"

  ext_dev_top #(
    .NUM_WORDS(NUM_WORDS)
  ) u_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .reg_valid_i    (reg_valid),
    .reg_write_i    (reg_write),
    .reg_addr_i     (reg_addr),
    .reg_wdata_i    (reg_wdata),
    .reg_ready_o    (reg_ready),
    .reg_rdata_o    (reg_rdata),
    .reg_error_o    (reg_error),
    .ext_p0_req_i   (p0_req),
    .ext_p0_we_i    (p0_we),
    .ext_p0_addr_i  (p0_addr),
    .ext_p0_wdata_i (p0_wdata),
    .ext_p0_be_i    (p0_be),
    .ext_p0_gnt_o   (p0_gnt),
    .ext_p0_rdata_o (p0_rdata),
    .ext_p0_rvalid_o(p0_rvalid),
    .memcopy_intr_o (memcopy_intr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  // Count interrupt pulses mid-cycle
  always @(negedge clk) begin
    if (memcopy_intr) begin
      intr_count <= intr_count + 1;
    end
  end

  task automatic check_config(input string name);
    logic [DATA_W-1:0] rdata;
    for (int r = 0; r < 3; r++) begin
      reg_read_ok(CFG_REGS[r], rdata);
      check_value($sformatf("%s reg %0d", name, r), cfg_shadow[r], rdata);
    end
  endtask

  task automatic test_registers();
    logic [DATA_W-1:0] rdata;
    reg_read_ok(REG_CTRL, rdata);
    check_value("status after reset", '0, rdata);
    cfg_shadow[0] = $urandom;
    cfg_shadow[1] = $urandom;
    cfg_shadow[2] = DATA_W'(1 + $urandom % NUM_WORDS);
    for (int r = 0; r < 3; r++) begin
      reg_write_ok(CFG_REGS[r], cfg_shadow[r]);
    end
    check_config("readback");
  endtask

  task automatic test_bad_access();
    logic [DATA_W-1:0]     rdata;
    logic                  error;
    logic [REG_ADDR_W-1:0] bad_addr;
    for (int k = 0; k < 4; k++) begin
      // Offsets off the word grid are unmapped
      bad_addr = REG_ADDR_W'(4 * ($urandom % 4) + 1 + $urandom % 3);
      reg_access(1'b1, bad_addr, $urandom, rdata, error);
      check_value("unmapped write error", 1, error);
      reg_access(1'b0, bad_addr, '0, rdata, error);
      check_value("unmapped read error", 1, error);
    end
    reg_access(1'b1, REG_SIZE, '0, rdata, error);
    check_value("size 0 error", 1, error);
    reg_access(1'b1, REG_SIZE, DATA_W'(NUM_WORDS + 1 + $urandom % 1000), rdata, error);
    check_value("size too large error", 1, error);
    check_config("after bad access");
    cfg_shadow[2] = DATA_W'(NUM_WORDS);
    reg_write_ok(REG_SIZE, cfg_shadow[2]);
    check_config("full size");
  endtask

  task automatic test_byte_writes();
    int unsigned       idx;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] rdata;
    for (int k = 0; k < NUM_BYTE_WR; k++) begin
      idx   = $urandom % NUM_WORDS;
      wdata = $urandom;
      be    = BE_W'($urandom);
      mem_access(1'b1, idx, wdata, be, rdata);
      model_write(idx, wdata, be);
      mem_access(1'b0, idx, '0, '0, rdata);
      check_value("byte write readback", model_mem[idx], rdata);
    end
  endtask

  task automatic test_random_copies();
    int unsigned src;
    int unsigned dst;
    int unsigned size;
    for (int k = 0; k < NUM_COPIES; k++) begin
      pick_copy(1, MAX_COPY, src, dst, size);
      start_copy(src, dst, size);
      wait_copy_done();
      check_memory($sformatf("random copy %0d", k));
    end
  endtask

  task automatic test_completion_status();
    int unsigned       src;
    int unsigned       dst;
    int unsigned       size;
    logic [DATA_W-1:0] rdata;
    pick_copy(MAX_COPY / 2, MAX_COPY, src, dst, size);
    start_copy(src, dst, size);
    reg_read_ok(REG_CTRL, rdata);
    check_value("status during copy", DATA_W'(1) << STAT_BUSY_BIT, rdata);
    // Second start while busy must not restart the engine
    reg_write_ok(REG_CTRL, DATA_W'(1) << CTRL_START_BIT);
    wait_copy_done();
    repeat (2 * TXN_CYCLES) @(negedge clk);
    check_value("intr pulses", copies_started, intr_count);
    reg_read_ok(REG_CTRL, rdata);
    check_value("status after copy", DATA_W'(1) << STAT_DONE_BIT, rdata);
    check_memory("status copy");
  endtask

  task automatic test_port0_priority();
    int unsigned       src;
    int unsigned       dst;
    int unsigned       size;
    int unsigned       free_idx;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    pick_copy(MAX_COPY / 2, MAX_COPY, src, dst, size);
    free_idx = 0;
    for (int unsigned i = 0; i < NUM_WORDS; i++) begin
      if ((i < src || i >= src + size) && (i < dst || i >= dst + size)) begin
        free_idx = i;
      end
    end
    start_copy(src, dst, size);
    for (int unsigned k = 0; k < 4; k++) begin
      mem_access(1'b0, src + k, '0, '0, rdata);
      check_value("port 0 read during copy", model_mem[src + k], rdata);
    end
    wdata = $urandom;
    mem_access(1'b1, free_idx, wdata, '1, rdata);
    model_write(free_idx, wdata, '1);
    mem_access(1'b0, free_idx, '0, '0, rdata);
    check_value("port 0 write during copy", model_mem[free_idx], rdata);
    wait_copy_done();
    check_memory("copy with port 0 traffic");
  endtask

  initial begin
    void'($urandom(32'hc328_4ed2));
    clk       = 1'b0;
    rst_n     = 1'b0;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    p0_req    = 1'b0;
    p0_we     = 1'b0;
    p0_addr   = '0;
    p0_wdata  = '0;
    p0_be     = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_registers();
    test_bad_access();
    preload_memory();
    test_byte_writes();
    test_random_copies();
    test_completion_status();
    test_port0_priority();
    $display("Simulation PASSED");
    $finish;
  end

endmodule
